/* design/wb_soc_pkg.sv */
/*
 * system bus package
 * widths, address map, register offsets and the bus request and
 * response types shared by the arbiter, decoder and the three slaves
 */

package wb_soc_pkg;

    // ------------------------------
    // bus widths
    // ------------------------------
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;
    localparam int WB_AWIDTH = 32;

    // boot memory, 2 KB
    localparam int BOOT_WORDS  = 512;
    localparam int BOOT_AWIDTH = $clog2(BOOT_WORDS);

    // ------------------------------
    // address map, top byte selects
    // ------------------------------
    localparam logic [WB_AWIDTH-1:0] BOOT_BASE  = 32'h0000_0000;
    localparam logic [WB_AWIDTH-1:0] TIMER_BASE = 32'h1300_0000;
    localparam logic [WB_AWIDTH-1:0] IRQ_BASE   = 32'h1400_0000;

    // raw status bit positions
    localparam int IRQ_SRCS      = 2;
    localparam int IRQ_SRC_SOFT  = 0;
    localparam int IRQ_SRC_TIMER = 1;

    typedef enum logic [1:0] {SEL_BOOT, SEL_TIMER, SEL_IRQ, SEL_NONE} slave_sel_e;

    typedef enum logic [1:0] {GNT_IDLE, GNT_DATA, GNT_INSTR} grant_e;

    // timer word offsets
    typedef enum logic [3:0] {
        TMR_LOAD  = 4'h0,
        TMR_VALUE = 4'h4,
        TMR_CTRL  = 4'h8,
        TMR_CLEAR = 4'hC
    } timer_reg_e;

    // interrupt controller offsets
    typedef enum logic [4:0] {
        IRQ_STATUS  = 5'h00,
        IRQ_RAW     = 5'h04,
        IRQ_EN_SET  = 5'h08,
        IRQ_EN_CLR  = 5'h0C,
        FIRQ_EN_SET = 5'h10,
        FIRQ_EN_CLR = 5'h14,
        SOFT_SET    = 5'h18,
        SOFT_CLR    = 5'h1C
    } irq_reg_e;

    // ------------------------------
    // bus cycle types
    // ------------------------------
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_SWIDTH-1:0] sel;
        logic [WB_AWIDTH-1:0] adr;
        logic [WB_DWIDTH-1:0] wdat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic                 err;
        logic [WB_DWIDTH-1:0] rdat;
    } wb_rsp_t;

endpackage

/* design/wb_arbiter.sv */
/*
 * two-master bus arbiter
 * fixed priority to the data master, registered grant held for
 * the whole bus cycle of the granted master
 */

`timescale 1ns/1ns

module wb_arbiter (
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  wb_soc_pkg::wb_req_t i_dm_req,
    input  wb_soc_pkg::wb_req_t i_im_req,
    input  wb_soc_pkg::wb_rsp_t i_bus_rsp,
    output wb_soc_pkg::wb_rsp_t o_dm_rsp,
    output wb_soc_pkg::wb_rsp_t o_im_rsp,
    output wb_soc_pkg::wb_req_t o_bus_req
);
    import wb_soc_pkg::*;

    grant_e state_q;
    grant_e state_d;

    // ------------------------------
    // grant state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            GNT_IDLE: begin
                // data master wins a tie
                if (i_dm_req.cyc) begin
                    state_d = GNT_DATA;
                end else if (i_im_req.cyc) begin
                    state_d = GNT_INSTR;
                end
            end
            GNT_DATA: begin
                // hand over directly when the other master waits
                if (!i_dm_req.cyc) begin
                    state_d = i_im_req.cyc ? GNT_INSTR : GNT_IDLE;
                end
            end
            GNT_INSTR: begin
                if (!i_im_req.cyc) begin
                    state_d = i_dm_req.cyc ? GNT_DATA : GNT_IDLE;
                end
            end
            default: state_d = GNT_IDLE;
        endcase
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            state_q <= GNT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // request and response steering
    // ------------------------------
    always_comb begin
        o_bus_req = '0;
        o_dm_rsp  = '0;
        o_im_rsp  = '0;
        case (state_q)
            GNT_DATA: begin
                o_bus_req = i_dm_req;
                o_dm_rsp  = i_bus_rsp;
            end
            GNT_INSTR: begin
                o_bus_req    = i_im_req;
                // instruction side is read only
                o_bus_req.we = 1'b0;
                o_im_rsp     = i_bus_rsp;
            end
            default: begin
                o_bus_req = '0;
            end
        endcase
    end

endmodule

/* design/wb_decoder.sv */
/*
 * bus address decoder
 * routes the shared request to one of three slaves by the top
 * address byte, muxes the response back, errors unmapped accesses
 */

`timescale 1ns/1ns

module wb_decoder (
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  wb_soc_pkg::wb_req_t i_bus_req,
    input  wb_soc_pkg::wb_rsp_t i_boot_rsp,
    input  wb_soc_pkg::wb_rsp_t i_timer_rsp,
    input  wb_soc_pkg::wb_rsp_t i_irq_rsp,
    output wb_soc_pkg::wb_rsp_t o_bus_rsp,
    output wb_soc_pkg::wb_req_t o_boot_req,
    output wb_soc_pkg::wb_req_t o_timer_req,
    output wb_soc_pkg::wb_req_t o_irq_req
);
    import wb_soc_pkg::*;

    slave_sel_e slave_sel;
    logic       err_q;

    // ------------------------------
    // address decode
    // ------------------------------
    always_comb begin
        case (i_bus_req.adr[31:24])
            BOOT_BASE[31:24]:  slave_sel = SEL_BOOT;
            TIMER_BASE[31:24]: slave_sel = SEL_TIMER;
            IRQ_BASE[31:24]:   slave_sel = SEL_IRQ;
            default:           slave_sel = SEL_NONE;
        endcase
    end

    // stb only reaches the selected slave
    always_comb begin
        o_boot_req      = i_bus_req;
        o_timer_req     = i_bus_req;
        o_irq_req       = i_bus_req;
        o_boot_req.stb  = i_bus_req.stb && (slave_sel == SEL_BOOT);
        o_timer_req.stb = i_bus_req.stb && (slave_sel == SEL_TIMER);
        o_irq_req.stb   = i_bus_req.stb && (slave_sel == SEL_IRQ);
    end

    // ------------------------------
    // unmapped access error
    // ------------------------------
    // one-cycle pulse, one cycle after stb
    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= i_bus_req.cyc && i_bus_req.stb && (slave_sel == SEL_NONE) && !err_q;
        end
    end

    // response mux, address is held until the response
    always_comb begin
        case (slave_sel)
            SEL_BOOT:  o_bus_rsp = i_boot_rsp;
            SEL_TIMER: o_bus_rsp = i_timer_rsp;
            SEL_IRQ:   o_bus_rsp = i_irq_rsp;
            default:   o_bus_rsp = '{ack: 1'b0, err: err_q, rdat: '0};
        endcase
    end

endmodule

/* design/boot_mem.sv */
/*
 * embedded boot memory
 * 2 KB single port, byte-select writes, registered read data
 */

`timescale 1ns/1ns

module boot_mem (
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  wb_soc_pkg::wb_req_t i_req,
    output wb_soc_pkg::wb_rsp_t o_rsp
);
    import wb_soc_pkg::*;

    logic [WB_DWIDTH-1:0]   mem [BOOT_WORDS];
    logic [BOOT_AWIDTH-1:0] idx;
    logic [WB_DWIDTH-1:0]   rdat_q;
    logic                   ack_q;
    logic                   access;

    // word index, adr bits 10 to 2
    assign idx    = i_req.adr[BOOT_AWIDTH+1:2];
    assign access = i_req.cyc && i_req.stb && !ack_q;

    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // write only the selected byte lanes
    always_ff @(posedge i_sys_clk) begin
        if (access && i_req.we) begin
            for (int b = 0; b < WB_SWIDTH; b++) begin
                if (i_req.sel[b]) begin
                    mem[idx][b*8 +: 8] <= i_req.wdat[b*8 +: 8];
                end
            end
        end
        if (access) begin
            rdat_q <= mem[idx];
        end
    end

    assign o_rsp = '{ack: ack_q, err: 1'b0, rdat: rdat_q};

endmodule

/* design/timer_module.sv */
/*
 * single channel timer
 * reloading down-counter, sets its interrupt flag at zero,
 * flag cleared by any write to CLEAR
 */

`timescale 1ns/1ns

module timer_module (
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  wb_soc_pkg::wb_req_t i_req,
    output wb_soc_pkg::wb_rsp_t o_rsp,
    output logic                o_timer_int
);
    import wb_soc_pkg::*;

    timer_reg_e           reg_off;
    logic                 access;
    logic                 wr_en;
    logic [WB_DWIDTH-1:0] load_q;
    logic [WB_DWIDTH-1:0] value_q;
    logic                 en_q;
    logic                 int_q;
    logic                 ack_q;
    logic [WB_DWIDTH-1:0] rdat_q;
    logic [WB_DWIDTH-1:0] rd_data;

    assign reg_off = timer_reg_e'(i_req.adr[3:0]);
    assign access  = i_req.cyc && i_req.stb && !ack_q;
    assign wr_en   = access && i_req.we;

    // ------------------------------
    // counter and registers
    // ------------------------------
    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            load_q  <= '0;
            value_q <= '0;
            en_q    <= 1'b0;
            int_q   <= 1'b0;
        end else begin
            // count down, reload at zero
            if (en_q) begin
                if (value_q == '0) begin
                    value_q <= load_q;
                end else begin
                    value_q <= value_q - 1'b1;
                end
            end
            if (wr_en && reg_off == TMR_CLEAR) begin
                int_q <= 1'b0;
            end
            // new zero crossing wins over a clear
            if (en_q && value_q == '0) begin
                int_q <= 1'b1;
            end
            // load also restarts the count
            if (wr_en && reg_off == TMR_LOAD) begin
                load_q  <= i_req.wdat;
                value_q <= i_req.wdat;
            end
            if (wr_en && reg_off == TMR_CTRL) begin
                en_q <= i_req.wdat[0];
            end
        end
    end

    // read mux
    always_comb begin
        case (reg_off)
            TMR_LOAD:  rd_data = load_q;
            TMR_VALUE: rd_data = value_q;
            TMR_CTRL:  rd_data = {{(WB_DWIDTH-1){1'b0}}, en_q};
            TMR_CLEAR: rd_data = {{(WB_DWIDTH-1){1'b0}}, int_q};
            default:   rd_data = '0;
        endcase
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (access) begin
            rdat_q <= rd_data;
        end
    end

    assign o_rsp       = '{ack: ack_q, err: 1'b0, rdat: rdat_q};
    assign o_timer_int = int_q;

endmodule

/* design/interrupt_controller.sv */
/*
 * interrupt controller
 * soft bit and timer flag as raw status, separate irq and firq
 * masks changed by set and clear writes, registered outputs
 */

`timescale 1ns/1ns

module interrupt_controller (
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  wb_soc_pkg::wb_req_t i_req,
    input  logic                i_timer_int,
    output wb_soc_pkg::wb_rsp_t o_rsp,
    output logic                o_irq,
    output logic                o_firq
);
    import wb_soc_pkg::*;

    irq_reg_e             reg_off;
    logic                 access;
    logic                 wr_en;
    logic                 soft_q;
    logic [IRQ_SRCS-1:0]  raw;
    logic [IRQ_SRCS-1:0]  irq_en_q;
    logic [IRQ_SRCS-1:0]  firq_en_q;
    logic                 irq_q;
    logic                 firq_q;
    logic                 ack_q;
    logic [WB_DWIDTH-1:0] rdat_q;
    logic [IRQ_SRCS-1:0]  rd_bits;

    assign reg_off = irq_reg_e'(i_req.adr[4:0]);
    assign access  = i_req.cyc && i_req.stb && !ack_q;
    assign wr_en   = access && i_req.we;

    always_comb begin
        raw                = '0;
        raw[IRQ_SRC_SOFT]  = soft_q;
        raw[IRQ_SRC_TIMER] = i_timer_int;
    end

    // ------------------------------
    // masks, soft bit, outputs
    // ------------------------------
    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            soft_q    <= 1'b0;
            irq_en_q  <= '0;
            firq_en_q <= '0;
            irq_q     <= 1'b0;
            firq_q    <= 1'b0;
        end else begin
            if (wr_en) begin
                case (reg_off)
                    IRQ_EN_SET:  irq_en_q  <= irq_en_q | i_req.wdat[IRQ_SRCS-1:0];
                    IRQ_EN_CLR:  irq_en_q  <= irq_en_q & ~i_req.wdat[IRQ_SRCS-1:0];
                    FIRQ_EN_SET: firq_en_q <= firq_en_q | i_req.wdat[IRQ_SRCS-1:0];
                    FIRQ_EN_CLR: firq_en_q <= firq_en_q & ~i_req.wdat[IRQ_SRCS-1:0];
                    // any write sets or clears the soft bit
                    SOFT_SET:    soft_q    <= 1'b1;
                    SOFT_CLR:    soft_q    <= 1'b0;
                    default:     soft_q    <= soft_q;
                endcase
            end
            irq_q  <= |(raw & irq_en_q);
            firq_q <= |(raw & firq_en_q);
        end
    end

    // status reads, mask offsets read back the mask
    always_comb begin
        case (reg_off)
            IRQ_STATUS:               rd_bits = raw & irq_en_q;
            IRQ_RAW:                  rd_bits = raw;
            IRQ_EN_SET, IRQ_EN_CLR:   rd_bits = irq_en_q;
            FIRQ_EN_SET, FIRQ_EN_CLR: rd_bits = firq_en_q;
            default:                  rd_bits = raw & firq_en_q;
        endcase
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (access) begin
            rdat_q <= {{(WB_DWIDTH-IRQ_SRCS){1'b0}}, rd_bits};
        end
    end

    assign o_rsp  = '{ack: ack_q, err: 1'b0, rdat: rdat_q};
    assign o_irq  = irq_q;
    assign o_firq = firq_q;

endmodule

/* design/wb_soc_top.sv */
/*
 * system bus top level
 * two external masters through the arbiter and decoder to the
 * boot memory, timer and interrupt controller
 */

`timescale 1ns/1ns

module wb_soc_top (
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  wb_soc_pkg::wb_req_t i_dm_req,
    input  wb_soc_pkg::wb_req_t i_im_req,
    output wb_soc_pkg::wb_rsp_t o_dm_rsp,
    output wb_soc_pkg::wb_rsp_t o_im_rsp,
    output logic                o_irq,
    output logic                o_firq
);
    import wb_soc_pkg::*;

    // shared bus
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;

    // per slave
    wb_req_t boot_req;
    wb_rsp_t boot_rsp;
    wb_req_t timer_req;
    wb_rsp_t timer_rsp;
    wb_req_t irq_req;
    wb_rsp_t irq_rsp;

    logic    timer_int;

    // ------------------------------
    // arbiter and decoder
    // ------------------------------
    wb_arbiter u_arbiter (
        .i_sys_clk (i_sys_clk),
        .i_rst_n   (i_rst_n),
        .i_dm_req  (i_dm_req),
        .i_im_req  (i_im_req),
        .i_bus_rsp (bus_rsp),
        .o_dm_rsp  (o_dm_rsp),
        .o_im_rsp  (o_im_rsp),
        .o_bus_req (bus_req)
    );

    wb_decoder u_decoder (
        .i_sys_clk   (i_sys_clk),
        .i_rst_n     (i_rst_n),
        .i_bus_req   (bus_req),
        .i_boot_rsp  (boot_rsp),
        .i_timer_rsp (timer_rsp),
        .i_irq_rsp   (irq_rsp),
        .o_bus_rsp   (bus_rsp),
        .o_boot_req  (boot_req),
        .o_timer_req (timer_req),
        .o_irq_req   (irq_req)
    );

    // ------------------------------
    // slaves
    // ------------------------------
    boot_mem u_boot_mem (
        .i_sys_clk (i_sys_clk),
        .i_rst_n   (i_rst_n),
        .i_req     (boot_req),
        .o_rsp     (boot_rsp)
    );

    timer_module u_timer_module (
        .i_sys_clk   (i_sys_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (timer_req),
        .o_rsp       (timer_rsp),
        .o_timer_int (timer_int)
    );

    interrupt_controller u_interrupt_controller (
        .i_sys_clk   (i_sys_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (irq_req),
        .i_timer_int (timer_int),
        .o_rsp       (irq_rsp),
        .o_irq       (o_irq),
        .o_firq      (o_firq)
    );

endmodule

/* sim/wb_soc_props.sv */
/*
 * bus protocol and reset properties
 * bound to the system bus top level
 */

`timescale 1ns/1ns

module wb_soc_props (
    input logic                i_sys_clk,
    input logic                i_rst_n,
    input wb_soc_pkg::wb_rsp_t i_dm_rsp,
    input wb_soc_pkg::wb_rsp_t i_im_rsp,
    input logic                i_irq,
    input logic                i_firq
);

    // ------------------------------
    // response encoding
    // ------------------------------
    a_dm_ack_err: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        !(i_dm_rsp.ack && i_dm_rsp.err))
        else $error("data master sees ack and err together");

    a_im_ack_err: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        !(i_im_rsp.ack && i_im_rsp.err))
        else $error("instruction master sees ack and err together");

    // ack lasts one cycle only
    a_dm_ack_pulse: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        i_dm_rsp.ack |=> !i_dm_rsp.ack)
        else $error("data master ack longer than one cycle");

    a_im_ack_pulse: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        i_im_rsp.ack |=> !i_im_rsp.ack)
        else $error("instruction master ack longer than one cycle");

    // ------------------------------
    // reset
    // ------------------------------
    a_irq_reset: assert property (@(posedge i_sys_clk)
        !i_rst_n |=> (!i_irq && !i_firq))
        else $error("interrupt lines high during reset");

endmodule

bind wb_soc_top wb_soc_props u_props (
    .i_sys_clk (i_sys_clk),
    .i_rst_n   (i_rst_n),
    .i_dm_rsp  (o_dm_rsp),
    .i_im_rsp  (o_im_rsp),
    .i_irq     (o_irq),
    .i_firq    (o_firq)
);

/* sim/tb_wb_soc_top.sv */
/*
 * testbench for the system bus top level
 * plays both masters, mirrors the boot memory in a model and
 * checks the timer and interrupt controller over the bus
 */

`timescale 1ns/1ns

module tb_wb_soc_top;
    import wb_soc_pkg::*;

    logic    sys_clk;
    logic    rst_n;
    wb_req_t dm_req;
    wb_req_t im_req;
    wb_rsp_t dm_rsp;
    wb_rsp_t im_rsp;
    logic    irq;
    logic    firq;

    // boot memory model
    logic [WB_DWIDTH-1:0] model [BOOT_WORDS];

    int checks;
    int errors;

    wb_soc_top i_wb_soc_top (
        .i_sys_clk (sys_clk),
        .i_rst_n   (rst_n),
        .i_dm_req  (dm_req),
        .i_im_req  (im_req),
        .o_dm_rsp  (dm_rsp),
        .o_im_rsp  (im_rsp),
        .o_irq     (irq),
        .o_firq    (firq)
    );

    // 20 ns period
    always #10 sys_clk = ~sys_clk;

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act,
                             input logic with_data);
        checks++;
        if (act.ack !== exp.ack || act.err !== exp.err ||
            (with_data && act.rdat !== exp.rdat)) begin
            errors++;
            $display("FAILED %s: expected ack=%b err=%b rdat=%h, actual ack=%b err=%b rdat=%h",
                     name, exp.ack, exp.err, exp.rdat, act.ack, act.err, act.rdat);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ------------------------------
    // model helpers
    // ------------------------------
    // sel picks the new byte lanes and the rest keeps the old word
    function automatic logic [WB_DWIDTH-1:0] merge_bytes(input logic [WB_DWIDTH-1:0] old_word,
                                                         input logic [WB_DWIDTH-1:0] new_word,
                                                         input logic [WB_SWIDTH-1:0] sel);
        logic [WB_DWIDTH-1:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // every index bit shows up twice
    function automatic logic [WB_DWIDTH-1:0] fill_word(input logic [BOOT_AWIDTH-1:0] idx);
        return {7'h2d, idx, 7'h51, ~idx};
    endfunction

    function automatic logic [WB_AWIDTH-1:0] boot_adr(input logic [BOOT_AWIDTH-1:0] idx);
        return {BOOT_BASE[WB_AWIDTH-1:BOOT_AWIDTH+2], idx, 2'b00};
    endfunction

    // ------------------------------
    // master drivers
    // ------------------------------
    // one data master bus cycle held until ack or err
    task automatic dm_access(input logic we, input logic [WB_SWIDTH-1:0] sel,
                             input logic [WB_AWIDTH-1:0] adr, input logic [WB_DWIDTH-1:0] wdat,
                             output wb_rsp_t rsp);
        int   cycles;
        logic done;
        @(posedge sys_clk);
        #2;
        dm_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, wdat: wdat};
        rsp    = '0;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < 32) begin
            @(posedge sys_clk);
            #1;
            cycles++;
            if (dm_rsp.ack || dm_rsp.err) begin
                rsp  = dm_rsp;
                done = 1'b1;
            end
        end
        if (!done) begin
            errors++;
            $display("data master got no response for address %h", adr);
        end
        #1;
        dm_req = '0;
    endtask

    // instruction master fetch, its we and wdat must not reach memory
    task automatic im_fetch(input logic [WB_AWIDTH-1:0] adr, output wb_rsp_t rsp);
        int   cycles;
        logic done;
        @(posedge sys_clk);
        #2;
        im_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: 4'hf, adr: adr, wdat: $urandom};
        rsp    = '0;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < 32) begin
            @(posedge sys_clk);
            #1;
            cycles++;
            if (im_rsp.ack || im_rsp.err) begin
                rsp  = im_rsp;
                done = 1'b1;
            end
        end
        if (!done) begin
            errors++;
            $display("instruction master got no response for address %h", adr);
        end
        #1;
        im_req = '0;
    endtask

    task automatic reg_write(input string name, input logic [WB_AWIDTH-1:0] adr,
                             input logic [WB_DWIDTH-1:0] wdat);
        wb_rsp_t rsp;
        wb_rsp_t exp;
        exp = '{ack: 1'b1, err: 1'b0, rdat: '0};
        dm_access(1'b1, 4'hf, adr, wdat, rsp);
        check_rsp(name, exp, rsp, 1'b0);
    endtask

    // poll the interrupt lines until they settle
    task automatic wait_irq_lines(input string name, input logic exp_irq, input logic exp_firq,
                                  input int limit);
        int cycles;
        cycles = 0;
        @(posedge sys_clk);
        #1;
        while ((irq !== exp_irq || firq !== exp_firq) && cycles < limit) begin
            @(posedge sys_clk);
            #1;
            cycles++;
        end
        if (irq !== exp_irq || firq !== exp_firq) begin
            $display("interrupt lines did not settle in time for %s", name);
        end
        check_bit({name, " irq"}, exp_irq, irq);
        check_bit({name, " firq"}, exp_firq, firq);
    endtask

    task automatic check_reset_outputs(input string name);
        check_bit({name, " irq"}, 1'b0, irq);
        check_bit({name, " firq"}, 1'b0, firq);
        check_bit({name, " dm ack"}, 1'b0, dm_rsp.ack);
        check_bit({name, " dm err"}, 1'b0, dm_rsp.err);
        check_bit({name, " im ack"}, 1'b0, im_rsp.ack);
        check_bit({name, " im err"}, 1'b0, im_rsp.err);
    endtask

    // ------------------------------
    // test sequences
    // ------------------------------
    // known contents for every word
    task automatic fill_boot();
        logic [BOOT_AWIDTH-1:0] idx;
        int i;
        for (i = 0; i < BOOT_WORDS; i++) begin
            idx      = BOOT_AWIDTH'(i);
            model[i] = fill_word(idx);
            reg_write($sformatf("fill %0d", i), boot_adr(idx), model[i]);
        end
    endtask

    // random byte-select writes and reads
    task automatic run_dm_traffic(input int count, input string tag);
        wb_rsp_t                rsp;
        wb_rsp_t                exp;
        logic [BOOT_AWIDTH-1:0] idx;
        logic [WB_SWIDTH-1:0]   sel;
        logic [WB_DWIDTH-1:0]   wdat;
        logic                   we;
        int                     n;
        for (n = 0; n < count; n++) begin
            idx  = BOOT_AWIDTH'($urandom_range(0, BOOT_WORDS - 1));
            we   = 1'($urandom_range(0, 1));
            sel  = WB_SWIDTH'($urandom);
            wdat = $urandom;
            if (we) begin
                exp = '{ack: 1'b1, err: 1'b0, rdat: '0};
                dm_access(1'b1, sel, boot_adr(idx), wdat, rsp);
                check_rsp($sformatf("%s write %0d", tag, n), exp, rsp, 1'b0);
                model[idx] = merge_bytes(model[idx], wdat, sel);
            end else begin
                dm_access(1'b0, 4'hf, boot_adr(idx), '0, rsp);
                exp = '{ack: 1'b1, err: 1'b0, rdat: model[idx]};
                check_rsp($sformatf("%s read %0d", tag, n), exp, rsp, 1'b1);
            end
        end
    endtask

    task automatic run_im_traffic(input int count);
        wb_rsp_t                rsp;
        wb_rsp_t                exp;
        logic [BOOT_AWIDTH-1:0] idx;
        int                     n;
        for (n = 0; n < count; n++) begin
            idx = BOOT_AWIDTH'($urandom_range(0, BOOT_WORDS - 1));
            im_fetch(boot_adr(idx), rsp);
            exp = '{ack: 1'b1, err: 1'b0, rdat: model[idx]};
            check_rsp($sformatf("fetch %0d", n), exp, rsp, 1'b1);
        end
    endtask

    task automatic check_unmapped(input int count);
        wb_rsp_t                rsp;
        wb_rsp_t                exp;
        logic [BOOT_AWIDTH-1:0] idx;
        logic [WB_AWIDTH-1:0]   adr;
        int                     n;
        for (n = 0; n < count; n++) begin
            idx = BOOT_AWIDTH'($urandom_range(0, BOOT_WORDS - 1));
            adr = boot_adr(idx);
            // top bytes above the interrupt controller are unmapped
            adr[31:24] = 8'($urandom_range(8'h15, 8'hff));
            exp = '{ack: 1'b0, err: 1'b1, rdat: '0};
            dm_access(1'b1, 4'hf, adr, $urandom, rsp);
            check_rsp($sformatf("unmapped write %h", adr), exp, rsp, 1'b1);
            dm_access(1'b0, 4'hf, adr, '0, rsp);
            check_rsp($sformatf("unmapped read %h", adr), exp, rsp, 1'b1);
            // aliased boot word must be untouched
            dm_access(1'b0, 4'hf, boot_adr(idx), '0, rsp);
            exp = '{ack: 1'b1, err: 1'b0, rdat: model[idx]};
            check_rsp($sformatf("boot after unmapped %0d", n), exp, rsp, 1'b1);
        end
    endtask

    task automatic test_soft_irq();
        wb_rsp_t rsp;
        wb_rsp_t exp;
        reg_write("soft set", IRQ_BASE + 32'(SOFT_SET), 32'h1);
        reg_write("irq enable soft", IRQ_BASE + 32'(IRQ_EN_SET), 32'h1 << IRQ_SRC_SOFT);
        wait_irq_lines("soft irq", 1'b1, 1'b0, 16);
        dm_access(1'b0, 4'hf, IRQ_BASE + 32'(IRQ_RAW), '0, rsp);
        exp = '{ack: 1'b1, err: 1'b0, rdat: 32'h1 << IRQ_SRC_SOFT};
        check_rsp("raw status soft", exp, rsp, 1'b1);
        dm_access(1'b0, 4'hf, IRQ_BASE + 32'(IRQ_STATUS), '0, rsp);
        check_rsp("masked status soft", exp, rsp, 1'b1);
        reg_write("firq enable soft", IRQ_BASE + 32'(FIRQ_EN_SET), 32'h1 << IRQ_SRC_SOFT);
        wait_irq_lines("soft firq", 1'b1, 1'b1, 16);
        reg_write("soft clear", IRQ_BASE + 32'(SOFT_CLR), 32'h1);
        wait_irq_lines("soft cleared", 1'b0, 1'b0, 16);
        // masks back to reset state
        reg_write("irq disable soft", IRQ_BASE + 32'(IRQ_EN_CLR), 32'h1 << IRQ_SRC_SOFT);
        reg_write("firq disable soft", IRQ_BASE + 32'(FIRQ_EN_CLR), 32'h1 << IRQ_SRC_SOFT);
    endtask

    task automatic test_timer_irq();
        wb_rsp_t              rsp;
        logic [WB_DWIDTH-1:0] load;
        load = $urandom_range(4, 24);
        reg_write("timer load", TIMER_BASE + 32'(TMR_LOAD), load);
        reg_write("irq enable timer", IRQ_BASE + 32'(IRQ_EN_SET), 32'h1 << IRQ_SRC_TIMER);
        reg_write("timer enable", TIMER_BASE + 32'(TMR_CTRL), 32'h1);
        wait_irq_lines("timer irq", 1'b1, 1'b0, 64);
        dm_access(1'b0, 4'hf, TIMER_BASE + 32'(TMR_VALUE), '0, rsp);
        check_bit("timer value ack", 1'b1, rsp.ack);
        check_bit("timer value within load", 1'b1, rsp.rdat <= load);
        // stop first so the flag stays clear
        reg_write("timer disable", TIMER_BASE + 32'(TMR_CTRL), 32'h0);
        reg_write("timer clear", TIMER_BASE + 32'(TMR_CLEAR), 32'h1);
        wait_irq_lines("timer cleared", 1'b0, 1'b0, 16);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        sys_clk = 1'b0;
        rst_n   = 1'b0;
        dm_req  = '0;
        im_req  = '0;
        checks  = 0;
        errors  = 0;
        void'($urandom(33636));

        // outputs quiet on every reset cycle
        repeat (10) begin
            @(posedge sys_clk);
            #1;
            check_reset_outputs("in reset");
        end
        #1;
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge sys_clk);
            #1;
            check_reset_outputs("after reset");
        end

        fill_boot();
        run_dm_traffic(200, "boot");
        // both masters contend for the bus
        fork
            run_dm_traffic(100, "shared");
            run_im_traffic(100);
        join
        check_unmapped(8);
        test_soft_irq();
        test_timer_irq();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* wb_soc.f */
design/wb_soc_pkg.sv
design/wb_arbiter.sv
design/wb_decoder.sv
design/boot_mem.sv
design/timer_module.sv
design/interrupt_controller.sv
design/wb_soc_top.sv
sim/wb_soc_props.sv
sim/tb_wb_soc_top.sv

/* Makefile */
# Verilator lint and simulation of the system bus

VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_wb_soc_top
FILELIST  := wb_soc.f
BUILD_DIR := obj_dir
SIM_BIN   := sim_$(TOP)
LOG       := sim.log
PASS_MSG  := TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
